/* all.f */
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_branch.sv
verilog/div_ctrl.sv
verilog/div_counter.sv
verilog/div_datapath.sv
verilog/ex_top.sv
tb/ex_asserts.sv
tb/tb_ex.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_ex -o tb_ex_sim \
	> build.log 2>&1 \
	&& ./obj_dir/tb_ex_sim > sim.log 2>&1 \
	|| { cat build.log; echo "build or simulation did not complete"; }
cat sim.log 2>/dev/null
grep -q "^RESULT: PASS$" sim.log 2>/dev/null && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* tb/ex_asserts.sv */
`timescale 1ns/1ps

module ex_asserts (
	input logic clk_i,
	input logic rst_n_i,
	input logic div_load_i,
	input logic div_ready_i,
	input logic div_busy_i,
	input logic reg_wen_i,
	input logic hold_flag_i
);

	// done comes alone, one full run after the capture
	ready_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		div_ready_i |-> ($past(div_load_i, ex_pkg::DIV_STEPS + 1) && !$past(div_ready_i)))
		else $error("div_ready not a single cycle one run after the capture");

	// hold spans the capture through the write-back cycle
	hold_covers_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(div_load_i || (div_busy_i && !div_ready_i)) |=> hold_flag_i)
		else $error("hold_flag_o dropped before the divider wrote back");

	div_write_in_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		div_busy_i |-> (reg_wen_i == div_ready_i)) // bubbles upstream while busy
		else $error("divider write outside the ready cycle");

endmodule

bind ex_top ex_asserts u_ex_asserts (
	.clk_i       (clk_i),
	.rst_n_i     (rst_n_i),
	.div_load_i  (div_load),
	.div_ready_i (div_ready),
	.div_busy_i  (div_busy),
	.reg_wen_i   (reg_wen_o),
	.hold_flag_i (hold_flag_o)
);

/* tb/tb_ex.sv */
`timescale 1ns/1ps

module tb_ex;

	localparam int TIMEOUT_CYCLES = 3000; // about 40 divides plus alu and branch work
	localparam int DIV_LATENCY    = 33;

	logic              clk_i;
	logic              rst_n_i;
	ex_pkg::inst_t     inst_i;
	ex_pkg::word_t     inst_addr_i;
	ex_pkg::word_t     op1_i;
	ex_pkg::word_t     op2_i;
	ex_pkg::reg_addr_t reg_waddr_i;
	logic              reg_wen_i;
	ex_pkg::word_t     reg_wdata_o;
	ex_pkg::reg_addr_t reg_waddr_o;
	logic              reg_wen_o;
	logic              jump_flag_o;
	ex_pkg::word_t     jump_addr_o;
	logic              hold_flag_o;

	int    seed;
	int    err_cnt;
	int    err_at_start;
	int    test_cnt;
	int    cycle_cnt = 0;
	string test_name;

	ex_top dut (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.inst_i      (inst_i),
		.inst_addr_i (inst_addr_i),
		.op1_i       (op1_i),
		.op2_i       (op2_i),
		.reg_waddr_i (reg_waddr_i),
		.reg_wen_i   (reg_wen_i),
		.reg_wdata_o (reg_wdata_o),
		.reg_waddr_o (reg_waddr_o),
		.reg_wen_o   (reg_wen_o),
		.jump_flag_o (jump_flag_o),
		.jump_addr_o (jump_addr_o),
		.hold_flag_o (hold_flag_o)
	);

	initial clk_i = 1'b0;
	always #10 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	function automatic ex_pkg::word_t rnd();
		return $random(seed);
	endfunction

	function automatic ex_pkg::inst_t enc_r(input logic [6:0] f7, input ex_pkg::funct3_t f3);
		return {f7, 5'd2, 5'd1, f3, 5'd3, ex_pkg::OPCODE_R_M};
	endfunction

	function automatic ex_pkg::inst_t enc_i(input logic [11:0] imm, input ex_pkg::funct3_t f3);
		return {imm, 5'd1, f3, 5'd3, ex_pkg::OPCODE_I};
	endfunction

	function automatic ex_pkg::inst_t enc_b(input logic [12:0] imm, input ex_pkg::funct3_t f3);
		return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], ex_pkg::OPCODE_B};
	endfunction

	// alt selects sub for add and the arithmetic form for right shifts
	function automatic ex_pkg::word_t alu_ref(input ex_pkg::funct3_t f3, input logic alt,
		input ex_pkg::word_t a, input ex_pkg::word_t b);
		ex_pkg::word_t r;
		logic [4:0]    sh;
		sh = b[4:0];
		case (f3)
			ex_pkg::F3_ADD:  r = alt ? a - b : a + b;
			ex_pkg::F3_SLL:  r = a << sh;
			ex_pkg::F3_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ex_pkg::F3_SLTU: r = (a < b) ? 32'd1 : 32'd0;
			ex_pkg::F3_XOR:  r = a ^ b;
			ex_pkg::F3_OR:   r = a | b;
			ex_pkg::F3_AND:  r = a & b;
			default: begin
				r = a >> sh;
				if (alt && a[31] && sh != 5'd0)
					r = r | ~(32'hffffffff >> sh); // fill vacated bits with the sign
			end
		endcase
		return r;
	endfunction

	function automatic logic branch_ref(input ex_pkg::funct3_t f3, input ex_pkg::word_t a,
		input ex_pkg::word_t b);
		case (f3)
			ex_pkg::F3_BEQ:  return a == b;
			ex_pkg::F3_BNE:  return a != b;
			ex_pkg::F3_BLT:  return $signed(a) < $signed(b);
			ex_pkg::F3_BGE:  return $signed(a) >= $signed(b);
			ex_pkg::F3_BLTU: return a < b;
			default:         return a >= b;
		endcase
	endfunction

	function automatic ex_pkg::word_t div_ref(input ex_pkg::funct3_t f3, input ex_pkg::word_t a,
		input ex_pkg::word_t b);
		logic is_rem;
		logic sgn;
		is_rem = (f3 == ex_pkg::F3_REM) || (f3 == ex_pkg::F3_REMU);
		sgn    = (f3 == ex_pkg::F3_DIV) || (f3 == ex_pkg::F3_REM);
		if (b == 32'd0)
			return is_rem ? a : 32'hffffffff;
		if (sgn && a == 32'h80000000 && b == 32'hffffffff)
			return is_rem ? 32'd0 : 32'h80000000; // signed overflow
		if (sgn)
			return is_rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
		return is_rem ? a % b : a / b;
	endfunction

	task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			err_cnt++;
			$display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic start_test(input string name);
		test_name    = name;
		err_at_start = err_cnt;
		test_cnt++;
	endtask

	task automatic finish_test();
		$display("test %s finished with %0d errors", test_name, err_cnt - err_at_start);
	endtask

	// inputs change on the falling edge, outputs are read 2 ns later
	task automatic drive(input ex_pkg::inst_t inst, input ex_pkg::word_t pc, input ex_pkg::word_t a,
		input ex_pkg::word_t b, input ex_pkg::reg_addr_t waddr, input logic wen);
		@(negedge clk_i);
		inst_i      = inst;
		inst_addr_i = pc;
		op1_i       = a;
		op2_i       = b;
		reg_waddr_i = waddr;
		reg_wen_i   = wen;
		#2;
	endtask

	task automatic run_alu(input ex_pkg::inst_t inst, input logic alt, input ex_pkg::word_t a,
		input ex_pkg::word_t b);
		ex_pkg::word_t w;
		w = rnd();
		drive(inst, rnd(), a, b, w[4:0], w[8]);
		check_val("wdata", alu_ref(inst[14:12], alt, a, b), reg_wdata_o);
		check_val("wen", {31'b0, w[8]}, {31'b0, reg_wen_o});
		check_val("waddr", {27'b0, w[4:0]}, {27'b0, reg_waddr_o});
		check_val("hold", 32'd0, {31'b0, hold_flag_o});
	endtask

	task automatic run_branch(input ex_pkg::funct3_t f3, input ex_pkg::word_t a,
		input ex_pkg::word_t b);
		ex_pkg::word_t w;
		ex_pkg::word_t pc;
		ex_pkg::word_t target;
		logic          taken;
		w      = rnd();
		pc     = rnd() & 32'hfffffffc;
		taken  = branch_ref(f3, a, b);
		target = pc + {{19{w[12]}}, w[12:1], 1'b0};
		drive(enc_b({w[12:1], 1'b0}, f3), pc, a, b, 5'd0, 1'b0);
		check_val("jump", {31'b0, taken}, {31'b0, jump_flag_o});
		check_val("hold", {31'b0, taken}, {31'b0, hold_flag_o});
		check_val("jump addr", taken ? target : 32'd0, jump_addr_o);
		check_val("wen", 32'd0, {31'b0, reg_wen_o});
	endtask

	task automatic run_div(input ex_pkg::funct3_t f3, input ex_pkg::word_t a, input ex_pkg::word_t b);
		ex_pkg::word_t     pc;
		ex_pkg::word_t     w;
		ex_pkg::reg_addr_t waddr;
		int                n;
		pc    = rnd() & 32'hfffffffc;
		w     = rnd();
		waddr = w[4:0];
		drive(enc_r(ex_pkg::FUNCT7_M, f3), pc, a, b, waddr, 1'b1);
		check_val("issue jump", 32'd1, {31'b0, jump_flag_o});
		check_val("issue hold", 32'd1, {31'b0, hold_flag_o});
		check_val("issue addr", pc + 32'd4, jump_addr_o);
		check_val("issue wen", 32'd0, {31'b0, reg_wen_o});
		@(posedge clk_i); // capture edge
		n = 0;
		do begin
			n++;
			drive(enc_i(12'd0, ex_pkg::F3_ADD), pc, rnd(), rnd(), 5'd0, 1'b0);
			check_val("busy hold", 32'd1, {31'b0, hold_flag_o});
		end while (!reg_wen_o && n < DIV_LATENCY + 4);
		if (!reg_wen_o) begin
			err_cnt++;
			$display("test %s: the divider never wrote back its result", test_name);
		end else begin
			check_val("latency", DIV_LATENCY, n);
			check_val("div result", div_ref(f3, a, b), reg_wdata_o);
			check_val("div waddr", {27'b0, waddr}, {27'b0, reg_waddr_o});
		end
	endtask

	task automatic test_alu_random();
		ex_pkg::word_t a;
		ex_pkg::word_t b;
		ex_pkg::word_t imm;
		int            i;
		start_test("alu_random");
		for (i = 0; i < 8; i++) begin
			a   = rnd();
			b   = rnd();
			imm = {{20{b[11]}}, b[11:0]};
			run_alu(enc_r(ex_pkg::FUNCT7_R, ex_pkg::F3_ADD), 1'b0, a, b);
			run_alu(enc_r(ex_pkg::FUNCT7_SUB_SRA, ex_pkg::F3_ADD), 1'b1, a, b);
			run_alu(enc_r(ex_pkg::FUNCT7_R, ex_pkg::F3_AND), 1'b0, a, b);
			run_alu(enc_r(ex_pkg::FUNCT7_R, ex_pkg::F3_OR), 1'b0, a, b);
			run_alu(enc_r(ex_pkg::FUNCT7_R, ex_pkg::F3_XOR), 1'b0, a, b);
			run_alu(enc_i(b[11:0], ex_pkg::F3_ADD), 1'b0, a, imm); // addi never subtracts
			run_alu(enc_i(b[11:0], ex_pkg::F3_AND), 1'b0, a, imm);
			run_alu(enc_i(b[11:0], ex_pkg::F3_OR), 1'b0, a, imm);
			run_alu(enc_i(b[11:0], ex_pkg::F3_XOR), 1'b0, a, imm);
		end
		finish_test();
	endtask

	task automatic test_shift_cmp();
		ex_pkg::word_t vals [5];
		ex_pkg::word_t shs [4];
		ex_pkg::word_t a;
		ex_pkg::word_t b;
		int            i;
		int            j;
		start_test("shift_cmp");
		vals = '{32'h80000000, 32'hffffffff, 32'h7fffffff, 32'h00000001, rnd()};
		shs  = '{32'd0, 32'd1, 32'd31, rnd()};
		for (i = 0; i < 5; i++) begin
			for (j = 0; j < 4; j++) begin
				a = vals[i];
				b = shs[j];
				run_alu(enc_r(ex_pkg::FUNCT7_R, ex_pkg::F3_SLL), 1'b0, a, b);
				run_alu(enc_r(ex_pkg::FUNCT7_R, ex_pkg::F3_SR), 1'b0, a, b);
				run_alu(enc_r(ex_pkg::FUNCT7_SUB_SRA, ex_pkg::F3_SR), 1'b1, a, b);
				run_alu(enc_i({7'b0100000, b[4:0]}, ex_pkg::F3_SR), 1'b1, a, 32'h400 | (b & 32'h1f));
				// compares against every edge value, equal pairs included
				run_alu(enc_r(ex_pkg::FUNCT7_R, ex_pkg::F3_SLT), 1'b0, a, vals[j]);
				run_alu(enc_r(ex_pkg::FUNCT7_R, ex_pkg::F3_SLTU), 1'b0, a, vals[j]);
			end
		end
		run_alu(enc_i(12'hfff, ex_pkg::F3_SLT), 1'b0, 32'd0, 32'hffffffff);
		run_alu(enc_i(12'hfff, ex_pkg::F3_SLTU), 1'b0, 32'd0, 32'hffffffff);
		finish_test();
	endtask

	task automatic test_branch();
		ex_pkg::word_t x;
		start_test("branch");
		x = rnd();
		run_branch(ex_pkg::F3_BEQ, x, x);                       // taken
		run_branch(ex_pkg::F3_BEQ, x, x + 32'd1);
		run_branch(ex_pkg::F3_BNE, x, x + 32'd1);               // taken
		run_branch(ex_pkg::F3_BNE, x, x);
		run_branch(ex_pkg::F3_BLT, 32'hfffffff0, 32'd5);        // taken
		run_branch(ex_pkg::F3_BLT, 32'd5, 32'hfffffff0);
		run_branch(ex_pkg::F3_BGE, 32'd5, 32'hfffffff0);        // taken
		run_branch(ex_pkg::F3_BGE, 32'hfffffff0, 32'd5);
		run_branch(ex_pkg::F3_BLTU, 32'd5, 32'hfffffff0);       // taken
		run_branch(ex_pkg::F3_BLTU, 32'hfffffff0, 32'd5);
		run_branch(ex_pkg::F3_BGEU, 32'hfffffff0, 32'd5);       // taken
		run_branch(ex_pkg::F3_BGEU, 32'd5, 32'hfffffff0);
		finish_test();
	endtask

	task automatic test_div_random();
		ex_pkg::word_t a;
		ex_pkg::word_t b;
		int            i;
		start_test("div_random");
		for (i = 0; i < 32; i++) begin
			a = rnd();
			b = rnd() >> (rnd() & 32'h1f); // spread the divisor sizes
			run_div(ex_pkg::funct3_t'(3'b100 | (i & 3)), a, b);
		end
		finish_test();
	endtask

	task automatic test_div_edge();
		ex_pkg::word_t a;
		start_test("div_edge");
		a = rnd();
		run_div(ex_pkg::F3_DIV, a, 32'd0);
		run_div(ex_pkg::F3_DIVU, a, 32'd0);
		run_div(ex_pkg::F3_REM, a, 32'd0);
		run_div(ex_pkg::F3_REMU, a, 32'd0);
		run_div(ex_pkg::F3_DIV, 32'h80000000, 32'hffffffff);
		run_div(ex_pkg::F3_REM, 32'h80000000, 32'hffffffff);
		run_div(ex_pkg::F3_DIVU, 32'h80000000, 32'hffffffff);
		finish_test();
	endtask

	task automatic test_div_then_alu();
		start_test("div_then_alu");
		run_div(ex_pkg::F3_DIV, rnd(), rnd() >> 8);
		run_alu(enc_r(ex_pkg::FUNCT7_SUB_SRA, ex_pkg::F3_ADD), 1'b1, rnd(), rnd());
		finish_test();
	endtask

	initial begin
		seed        = 32'haa4;
		err_cnt     = 0;
		test_cnt    = 0;
		rst_n_i     = 1'b0;
		inst_i      = '0;
		inst_addr_i = '0;
		op1_i       = '0;
		op2_i       = '0;
		reg_waddr_i = '0;
		reg_wen_i   = 1'b0;
		repeat (3) @(negedge clk_i);
		rst_n_i = 1'b1;
		test_alu_random();
		test_shift_cmp();
		test_branch();
		test_div_random();
		test_div_edge();
		test_div_then_alu();
		$display("%0d tests run, %0d errors", test_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* verilog/div_counter.sv */
`timescale 1ns/1ps

module div_counter (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic clear_i,
	input  logic step_i,
	output logic last_step_o
);

	ex_pkg::step_cnt_t cnt;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cnt <= '0;
		end else if (clear_i) begin
			cnt <= '0;
		end else if (step_i) begin
			cnt <= cnt + 1'b1;
		end
	end

	// high during the final step of the run
	assign last_step_o = step_i && (cnt == ex_pkg::step_cnt_t'(ex_pkg::DIV_STEPS - 1));

endmodule

/* verilog/div_ctrl.sv */
`timescale 1ns/1ps

module div_ctrl (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              div_req_i,
	input  ex_pkg::funct3_t   funct3_i,
	input  ex_pkg::reg_addr_t reg_waddr_i,
	input  logic              last_step_i,
	output logic              div_busy_o,
	output logic              div_ready_o,
	output logic              div_load_o,
	output logic              div_step_o,
	output logic              cnt_clear_o,
	output ex_pkg::reg_addr_t waddr_o,
	output ex_pkg::funct3_t   op_o
);

	ex_pkg::div_state_t state;
	ex_pkg::div_state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			ex_pkg::DIV_IDLE: if (div_req_i) state_nxt = ex_pkg::DIV_RUN;
			ex_pkg::DIV_RUN:  if (last_step_i) state_nxt = ex_pkg::DIV_DONE;
			ex_pkg::DIV_DONE: state_nxt = ex_pkg::DIV_IDLE;
			default:          state_nxt = ex_pkg::DIV_IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= ex_pkg::DIV_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// requests outside idle are dropped
	assign div_load_o  = (state == ex_pkg::DIV_IDLE) && div_req_i;
	assign cnt_clear_o = div_load_o;
	assign div_step_o  = (state == ex_pkg::DIV_RUN);
	assign div_ready_o = (state == ex_pkg::DIV_DONE);
	assign div_busy_o  = (state == ex_pkg::DIV_RUN) || (state == ex_pkg::DIV_DONE); // keeps hold over the write

	// destination and op for the write-back cycle
	always_ff @(posedge clk_i) begin
		if (div_load_o) begin
			waddr_o <= reg_waddr_i;
			op_o    <= funct3_i;
		end
	end

endmodule

/* verilog/div_datapath.sv */
`timescale 1ns/1ps

module div_datapath (
	input  logic            clk_i,
	input  logic            rst_n_i,
	input  logic            load_i,
	input  logic            step_i,
	input  ex_pkg::funct3_t op_load_i,
	input  ex_pkg::funct3_t op_i,
	input  ex_pkg::word_t   dividend_i,
	input  ex_pkg::word_t   divisor_i,
	output ex_pkg::word_t   result_o
);

	logic          op_signed;
	logic          dvd_neg_in;
	logic          dvsr_neg_in;
	ex_pkg::word_t dvd_mag;
	ex_pkg::word_t dvsr_mag;

	ex_pkg::word_t quo;  // dividend shifts out, quotient shifts in
	ex_pkg::word_t rem;
	ex_pkg::word_t dvsr;
	logic          dvd_neg;
	logic          dvsr_neg;
	logic          dvsr_zero;

	logic [32:0]   shifted;
	logic [32:0]   trial;
	ex_pkg::word_t quo_fix;
	ex_pkg::word_t rem_fix;
	logic          quo_neg;

	assign op_signed   = (op_load_i == ex_pkg::F3_DIV) || (op_load_i == ex_pkg::F3_REM);
	assign dvd_neg_in  = op_signed && dividend_i[31];
	assign dvsr_neg_in = op_signed && divisor_i[31];
	assign dvd_mag     = dvd_neg_in ? -dividend_i : dividend_i;
	assign dvsr_mag    = dvsr_neg_in ? -divisor_i : divisor_i;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dvd_neg   <= 1'b0;
			dvsr_neg  <= 1'b0;
			dvsr_zero <= 1'b0;
		end else if (load_i) begin
			dvd_neg   <= dvd_neg_in;
			dvsr_neg  <= dvsr_neg_in;
			dvsr_zero <= (divisor_i == '0);
		end
	end

	// partial remainder is below the divisor, so one extra bit is enough
	assign shifted = {rem, quo[31]};
	assign trial   = shifted - {1'b0, dvsr};

	always_ff @(posedge clk_i) begin
		if (load_i) begin
			quo  <= dvd_mag;
			rem  <= '0;
			dvsr <= dvsr_mag;
		end else if (step_i) begin
			if (!trial[32]) begin
				rem <= trial[31:0];
				quo <= {quo[30:0], 1'b1};
			end else begin
				rem <= shifted[31:0]; // restore
				quo <= {quo[30:0], 1'b0};
			end
		end
	end

	// zero divisor leaves all ones in quo and the dividend in rem
	assign quo_neg = (dvd_neg ^ dvsr_neg) && !dvsr_zero;
	assign quo_fix = quo_neg ? -quo : quo;
	assign rem_fix = dvd_neg ? -rem : rem;

	always_comb begin
		case (op_i)
			ex_pkg::F3_REM, ex_pkg::F3_REMU: result_o = rem_fix;
			default:                         result_o = quo_fix;
		endcase
	end

endmodule

/* verilog/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
	input  ex_pkg::inst_t inst_i,
	input  ex_pkg::word_t op1_i,
	input  ex_pkg::word_t op2_i,
	input  logic          reg_wen_i,
	output ex_pkg::word_t alu_wdata_o,
	output logic          alu_wen_o,
	output logic          div_req_o
);

	logic [6:0]      opcode;
	logic [6:0]      funct7;
	ex_pkg::funct3_t funct3;
	logic            is_i;
	logic            is_r;
	logic            is_r_alu;
	logic            is_m;
	logic [4:0]      shamt;
	ex_pkg::word_t   sum;
	ex_pkg::word_t   diff;
	ex_pkg::word_t   srl_res;
	ex_pkg::word_t   sra_res;
	logic            lt_s;
	logic            lt_u;
	ex_pkg::word_t   res;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	assign is_i     = (opcode == ex_pkg::OPCODE_I);
	assign is_r     = (opcode == ex_pkg::OPCODE_R_M);
	assign is_r_alu = is_r && ((funct7 == ex_pkg::FUNCT7_R) ||
		(funct7 == ex_pkg::FUNCT7_SUB_SRA));
	assign is_m     = is_r && (funct7 == ex_pkg::FUNCT7_M);

	assign shamt = op2_i[4:0];

	assign sum     = op1_i + op2_i;
	assign diff    = op1_i - op2_i;
	assign srl_res = op1_i >> shamt;
	assign sra_res = ex_pkg::word_t'($signed(op1_i) >>> shamt);
	assign lt_s    = ($signed(op1_i) < $signed(op2_i));
	assign lt_u    = (op1_i < op2_i);

	always_comb begin
		case (funct3)
			ex_pkg::F3_ADD: begin
				// bit 30 is immediate data for addi
				res = (is_r && inst_i[30]) ? diff : sum;
			end
			ex_pkg::F3_SLL:  res = op1_i << shamt;
			ex_pkg::F3_SLT:  res = {31'b0, lt_s};
			ex_pkg::F3_SLTU: res = {31'b0, lt_u};
			ex_pkg::F3_XOR:  res = op1_i ^ op2_i;
			ex_pkg::F3_SR:   res = inst_i[30] ? sra_res : srl_res; // srai / sra
			ex_pkg::F3_OR:   res = op1_i | op2_i;
			ex_pkg::F3_AND:  res = op1_i & op2_i;
			default:         res = '0;
		endcase
	end

	always_comb begin
		div_req_o = 1'b0;
		if (is_m) begin
			case (funct3)
				ex_pkg::F3_DIV, ex_pkg::F3_DIVU,
				ex_pkg::F3_REM, ex_pkg::F3_REMU: div_req_o = 1'b1;
				default:                         div_req_o = 1'b0;
			endcase
		end
	end

	// mul and other opcodes leave zero
	assign alu_wdata_o = (is_i || is_r_alu) ? res : '0;

	// divider writes back later
	assign alu_wen_o = div_req_o ? 1'b0 : reg_wen_i;

endmodule

/* verilog/ex_branch.sv */
`timescale 1ns/1ps

module ex_branch (
	input  ex_pkg::inst_t inst_i,
	input  ex_pkg::word_t inst_addr_i,
	input  ex_pkg::word_t op1_i,
	input  ex_pkg::word_t op2_i,
	output logic          br_jump_o,
	output ex_pkg::word_t br_addr_o
);

	ex_pkg::word_t b_imm;
	logic          is_b;
	logic          eq;
	logic          lt_s;
	logic          lt_u;
	logic          taken;

	assign is_b = (inst_i[6:0] == ex_pkg::OPCODE_B);

	// scrambled b-type immediate, lsb always zero
	assign b_imm = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
		inst_i[11:8], 1'b0};

	assign eq   = (op1_i == op2_i);
	assign lt_s = ($signed(op1_i) < $signed(op2_i));
	assign lt_u = (op1_i < op2_i);

	always_comb begin
		case (inst_i[14:12])
			ex_pkg::F3_BEQ:  taken = eq;
			ex_pkg::F3_BNE:  taken = !eq;
			ex_pkg::F3_BLT:  taken = lt_s;
			ex_pkg::F3_BGE:  taken = !lt_s;
			ex_pkg::F3_BLTU: taken = lt_u;
			ex_pkg::F3_BGEU: taken = !lt_u;
			default:         taken = 1'b0; // 010 and 011 are reserved
		endcase
	end

	assign br_jump_o = is_b && taken;
	assign br_addr_o = br_jump_o ? (inst_addr_i + b_imm) : '0;

endmodule

/* verilog/ex_pkg.sv */
package ex_pkg;

	// widths fixed by the isa
	typedef logic [31:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [5:0]  step_cnt_t;

	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_DONE
	} div_state_t;

	// major opcodes
	localparam logic [6:0] OPCODE_I   = 7'b0010011;
	localparam logic [6:0] OPCODE_R_M = 7'b0110011;
	localparam logic [6:0] OPCODE_B   = 7'b1100011;

	localparam logic [6:0] FUNCT7_R       = 7'b0000000;
	localparam logic [6:0] FUNCT7_SUB_SRA = 7'b0100000;
	localparam logic [6:0] FUNCT7_M       = 7'b0000001;

	// alu, shared by the r and i forms
	localparam funct3_t F3_ADD  = 3'b000;
	localparam funct3_t F3_SLL  = 3'b001;
	localparam funct3_t F3_SLT  = 3'b010;
	localparam funct3_t F3_SLTU = 3'b011;
	localparam funct3_t F3_XOR  = 3'b100;
	localparam funct3_t F3_SR   = 3'b101;
	localparam funct3_t F3_OR   = 3'b110;
	localparam funct3_t F3_AND  = 3'b111;

	// m extension, divide half only
	localparam funct3_t F3_DIV  = 3'b100;
	localparam funct3_t F3_DIVU = 3'b101;
	localparam funct3_t F3_REM  = 3'b110;
	localparam funct3_t F3_REMU = 3'b111;

	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	// one quotient bit per step
	localparam int DIV_STEPS = 32;

	localparam word_t INST_BYTES = 32'd4; // next pc after a divide

endpackage

/* verilog/ex_top.sv */
`timescale 1ns/1ps

module ex_top (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  ex_pkg::inst_t     inst_i,
	input  ex_pkg::word_t     inst_addr_i,
	input  ex_pkg::word_t     op1_i,
	input  ex_pkg::word_t     op2_i,
	input  ex_pkg::reg_addr_t reg_waddr_i,
	input  logic              reg_wen_i,
	output ex_pkg::word_t     reg_wdata_o,
	output ex_pkg::reg_addr_t reg_waddr_o,
	output logic              reg_wen_o,
	output logic              jump_flag_o,
	output ex_pkg::word_t     jump_addr_o,
	output logic              hold_flag_o
);

	ex_pkg::funct3_t   funct3;
	ex_pkg::word_t     alu_wdata;
	logic              alu_wen;
	logic              div_req;
	logic              br_jump;
	ex_pkg::word_t     br_addr;
	logic              div_busy;
	logic              div_ready;
	logic              div_load;
	logic              div_step;
	logic              cnt_clear;
	ex_pkg::reg_addr_t div_result_waddr;
	ex_pkg::funct3_t   div_result_op;
	logic              last_step;
	ex_pkg::word_t     div_result;

	assign funct3 = inst_i[14:12];

	ex_alu u_alu (
		.inst_i      (inst_i),
		.op1_i       (op1_i),
		.op2_i       (op2_i),
		.reg_wen_i   (reg_wen_i),
		.alu_wdata_o (alu_wdata),
		.alu_wen_o   (alu_wen),
		.div_req_o   (div_req)
	);

	ex_branch u_branch (
		.inst_i      (inst_i),
		.inst_addr_i (inst_addr_i),
		.op1_i       (op1_i),
		.op2_i       (op2_i),
		.br_jump_o   (br_jump),
		.br_addr_o   (br_addr)
	);

	div_ctrl u_div_ctrl (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.div_req_i   (div_req),
		.funct3_i    (funct3),
		.reg_waddr_i (reg_waddr_i),
		.last_step_i (last_step),
		.div_busy_o  (div_busy),
		.div_ready_o (div_ready),
		.div_load_o  (div_load),
		.div_step_o  (div_step),
		.cnt_clear_o (cnt_clear),
		.waddr_o     (div_result_waddr),
		.op_o        (div_result_op)
	);

	div_counter u_div_counter (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.clear_i     (cnt_clear),
		.step_i      (div_step),
		.last_step_o (last_step)
	);

	div_datapath u_div_datapath (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.load_i     (div_load),
		.step_i     (div_step),
		.op_load_i  (funct3),
		.op_i       (div_result_op),
		.dividend_i (op1_i),
		.divisor_i  (op2_i),
		.result_o   (div_result)
	);

	// divide issue flushes and refetches the next instruction
	assign jump_flag_o = br_jump || div_req;
	assign jump_addr_o = div_req ? (inst_addr_i + ex_pkg::INST_BYTES) : br_addr;
	assign hold_flag_o = br_jump || div_req || div_busy;

	// upstream only sends bubbles while the divider owns the port
	assign reg_wdata_o = div_ready ? div_result : alu_wdata;
	assign reg_waddr_o = div_ready ? div_result_waddr : reg_waddr_i;
	assign reg_wen_o   = div_ready || alu_wen;

endmodule
